// File: hdl/ahb_pkg.sv
package ahb_pkg;

    // transfer type on htrans
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // only word transfers are accepted
    localparam logic [2:0] hsize_word = 3'd2;

    // single, or incrementing of length one
    localparam logic [2:0] hburst_single = 3'b000;
    localparam logic [2:0] hburst_incr   = 3'b001;

    localparam logic hresp_okay  = 1'b0;
    localparam logic hresp_error = 1'b1;

    // address phase as held for the data phase
    typedef struct packed {
        logic       valid;
        logic       write;
        logic       size_ok;
        logic [3:0] offset;
        logic       mapped;
    } ahb_addr_phase_t;

endpackage

// File: hdl/gpio_pkg.sv
package gpio_pkg;

    // register map, low address bits
    localparam logic [3:0] gpio_data_off = 4'h0;
    localparam logic [3:0] gpio_ctrl_off = 4'h4;

    // two mode bits per pin, RSVD acts as HIZ
    typedef enum logic [1:0] {
        HIZ  = 2'd0,
        OUT  = 2'd1,
        IN   = 2'd2,
        RSVD = 2'd3
    } gpio_mode_e;

    // write request from the bus side, enables are one-hot or zero
    typedef struct packed {
        logic [31:0] wr_data;
        logic        wr_ctrl;
        logic        wr_data_en;
    } gpio_reg_req_t;

endpackage

// File: hdl/gpio_ahb_if.sv
`timescale 1ns/1ps

module gpio_ahb_if
    import ahb_pkg::*;
    import gpio_pkg::*;
#(
    parameter int AWIDTH = 32
) (
    input  logic                hclk,
    input  logic                hresetn,

    input  logic                hsel_i,
    input  logic [AWIDTH-1:0]   haddr_i,
    input  logic [1:0]          htrans_i,
    input  logic                hwrite_i,
    input  logic [2:0]          hsize_i,
    input  logic [2:0]          hburst_i,
    input  logic                hready_i,
    input  logic [31:0]         hwdata_i,

    input  logic [31:0]         ctrl_q_i,
    input  logic [31:0]         data_q_i,

    output logic                hreadyout_o,
    output logic                hresp_o,
    output logic [31:0]         hrdata_o,
    output gpio_reg_req_t       req_o
);

    typedef enum logic {
        ERR_NONE,
        ERR_LAST
    } err_state_e;

    htrans_e         trans;
    logic            burst_ok;
    logic            offset_known;
    logic            accept;
    logic            bad_xfer;
    logic            err_first;
    logic            ok_write;
    logic            ok_read;
    ahb_addr_phase_t addr_d;
    ahb_addr_phase_t addr_q;
    err_state_e      err_state_q;
    err_state_e      err_state_d;

    assign trans    = htrans_e'(htrans_i);
    assign burst_ok = (hburst_i == hburst_single) || (hburst_i == hburst_incr);

    assign offset_known = (haddr_i[3:0] == gpio_data_off) ||
                          (haddr_i[3:0] == gpio_ctrl_off);

    always_comb begin
        addr_d.valid   = hsel_i && ((trans == NONSEQ) || (trans == SEQ));
        addr_d.write   = hwrite_i;
        addr_d.size_ok = (hsize_i == hsize_word);
        addr_d.offset  = haddr_i[3:0];
        addr_d.mapped  = offset_known && addr_d.size_ok && burst_ok;
    end

    // no new address phase while the first error cycle is on the bus
    assign accept = hready_i && !err_first;

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            addr_q <= '0;
        end else if (accept) begin
            addr_q <= addr_d;
        end
    end

    assign bad_xfer  = addr_q.valid && !addr_q.mapped;
    assign err_first = bad_xfer && (err_state_q == ERR_NONE);

    always_comb begin
        err_state_d = err_state_q;
        if (err_first) begin
            err_state_d = ERR_LAST;
        end else if (accept) begin
            err_state_d = ERR_NONE;
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            err_state_q <= ERR_NONE;
        end else begin
            err_state_q <= err_state_d;
        end
    end

    assign hreadyout_o = !err_first;
    assign hresp_o     = bad_xfer ? hresp_error : hresp_okay;

    assign ok_write = addr_q.valid && addr_q.mapped && addr_q.write && hready_i;
    assign ok_read  = addr_q.valid && addr_q.mapped && !addr_q.write;

    // write lands on the edge that closes the data phase
    always_comb begin
        req_o.wr_data    = hwdata_i;
        req_o.wr_ctrl    = ok_write && (addr_q.offset == gpio_ctrl_off);
        req_o.wr_data_en = ok_write && (addr_q.offset == gpio_data_off);
    end

    always_comb begin
        hrdata_o = '0;
        if (ok_read) begin
            if (addr_q.offset == gpio_ctrl_off) begin
                hrdata_o = ctrl_q_i;
            end else begin
                hrdata_o = data_q_i;
            end
        end
    end

endmodule

// File: hdl/gpio_core.sv
`timescale 1ns/1ps

module gpio_core
    import gpio_pkg::*;
#(
    parameter int NUM_PINS = 4
) (
    input  logic                hclk,
    input  logic                hresetn,

    input  gpio_reg_req_t       req_i,

    output logic [31:0]         ctrl_q_o,
    output logic [31:0]         data_q_o,

    inout  wire  [NUM_PINS-1:0] pin_io
);

    localparam int CTRL_BITS = 2 * NUM_PINS;

    logic [CTRL_BITS-1:0] ctrl_q;
    logic [NUM_PINS-1:0]  data_q;
    logic [NUM_PINS-1:0]  data_d;
    logic [NUM_PINS-1:0]  sync1_q;
    logic [NUM_PINS-1:0]  sync2_q;
    logic [NUM_PINS-1:0]  in_mode;
    logic [NUM_PINS-1:0]  out_mode;
    logic [NUM_PINS-1:0]  oe_q;
    gpio_mode_e           pin_mode [NUM_PINS];

    // control register, bits above the mode fields are not stored
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ctrl_q <= '0;
        end else if (req_i.wr_ctrl) begin
            ctrl_q <= req_i.wr_data[CTRL_BITS-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PINS; i++) begin
            pin_mode[i] = gpio_mode_e'(ctrl_q[2*i +: 2]);
            in_mode[i]  = (pin_mode[i] == IN);
            out_mode[i] = (pin_mode[i] == OUT);
        end
    end

    // two-flop synchronizer on the pad levels
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= pin_io;
            sync2_q <= sync1_q;
        end
    end

    // input pins win over a bus write
    always_comb begin
        data_d = data_q;
        if (req_i.wr_data_en) begin
            data_d = req_i.wr_data[NUM_PINS-1:0];
        end
        data_d = (data_d & ~in_mode) | (sync2_q & in_mode);
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            data_q <= '0;
        end else begin
            data_q <= data_d;
        end
    end

    // enables follow the control register by one cycle
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            oe_q <= '0;
        end else begin
            oe_q <= out_mode;
        end
    end

    for (genvar i = 0; i < NUM_PINS; i++) begin : g_pad
        assign pin_io[i] = oe_q[i] ? data_q[i] : 1'bz;
    end

    always_comb begin
        ctrl_q_o = '0;
        ctrl_q_o[CTRL_BITS-1:0] = ctrl_q;
    end

    always_comb begin
        data_q_o = '0;
        data_q_o[NUM_PINS-1:0] = data_q;
    end

endmodule

// File: hdl/gpio_subsys_top.sv
`timescale 1ns/1ps

module gpio_subsys_top
    import gpio_pkg::*;
#(
    parameter int AWIDTH   = 32,
    parameter int NUM_PINS = 4
) (
    input  logic                hclk,
    input  logic                hresetn,

    input  logic                hsel_i,
    input  logic [AWIDTH-1:0]   haddr_i,
    input  logic [1:0]          htrans_i,
    input  logic                hwrite_i,
    input  logic [2:0]          hsize_i,
    input  logic [2:0]          hburst_i,
    input  logic                hready_i,
    input  logic [31:0]         hwdata_i,

    output logic                hreadyout_o,
    output logic                hresp_o,
    output logic [31:0]         hrdata_o,

    inout  wire  [NUM_PINS-1:0] pin_io
);

    gpio_reg_req_t req;
    logic [31:0]   ctrl_q;
    logic [31:0]   data_q;

    gpio_ahb_if #(
        .AWIDTH (AWIDTH)
    ) i_ahb_if (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .hsel_i      (hsel_i),
        .haddr_i     (haddr_i),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .hsize_i     (hsize_i),
        .hburst_i    (hburst_i),
        .hready_i    (hready_i),
        .hwdata_i    (hwdata_i),
        .ctrl_q_i    (ctrl_q),
        .data_q_i    (data_q),
        .hreadyout_o (hreadyout_o),
        .hresp_o     (hresp_o),
        .hrdata_o    (hrdata_o),
        .req_o       (req)
    );

    gpio_core #(
        .NUM_PINS (NUM_PINS)
    ) i_core (
        .hclk     (hclk),
        .hresetn  (hresetn),
        .req_i    (req),
        .ctrl_q_o (ctrl_q),
        .data_q_o (data_q),
        .pin_io   (pin_io)
    );

endmodule

// File: sim/gpio_bus_checker.sv
`timescale 1ns/1ps

module gpio_bus_checker (
    input logic        hclk,
    input logic        hresetn,
    input logic        hsel_i,
    input logic [1:0]  htrans_i,
    input logic        hwrite_i,
    input logic        hready_i,
    input logic        hreadyout_i,
    input logic        hresp_i,
    input logic [31:0] hrdata_i,
    input logic        wr_ctrl_i,
    input logic        wr_data_i
);

    logic rd_phase_q;
    logic wr_phase_q;
    int   fail_count = 0;

    // data phase of a selected nonseq or seq transfer
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            rd_phase_q <= 1'b0;
            wr_phase_q <= 1'b0;
        end else if (hready_i) begin
            rd_phase_q <= hsel_i && htrans_i[1] && !hwrite_i;
            wr_phase_q <= hsel_i && htrans_i[1] && hwrite_i;
        end
    end

    // first error cycle is always followed by the second one
    err_two_cycles: assert property (@(posedge hclk) disable iff (!hresetn)
        (hresp_i && !hreadyout_i) |=> (hresp_i && hreadyout_i))
        else begin
            $error("error response did not finish in its second cycle");
            fail_count = fail_count + 1;
        end

    // second cycle only after a first one
    err_second_after_first: assert property (@(posedge hclk) disable iff (!hresetn)
        (hresp_i && hreadyout_i) |-> $past(hresp_i && !hreadyout_i))
        else begin
            $error("error response without a first wait cycle");
            fail_count = fail_count + 1;
        end

    rdata_zero: assert property (@(posedge hclk) disable iff (!hresetn)
        !rd_phase_q |-> (hrdata_i == 32'h0))
        else begin
            $error("hrdata_o not zero outside a read data phase");
            fail_count = fail_count + 1;
        end

    // enables only in an okay write data phase, never both
    wr_en_okay: assert property (@(posedge hclk) disable iff (!hresetn)
        (wr_ctrl_i || wr_data_i) |->
            (wr_phase_q && !hresp_i && !(wr_ctrl_i && wr_data_i)))
        else begin
            $error("register write enable outside an okay write data phase");
            fail_count = fail_count + 1;
        end

endmodule

bind gpio_ahb_if gpio_bus_checker i_bus_chk (
    .hclk        (hclk),
    .hresetn     (hresetn),
    .hsel_i      (hsel_i),
    .htrans_i    (htrans_i),
    .hwrite_i    (hwrite_i),
    .hready_i    (hready_i),
    .hreadyout_i (hreadyout_o),
    .hresp_i     (hresp_o),
    .hrdata_i    (hrdata_o),
    .wr_ctrl_i   (req_o.wr_ctrl),
    .wr_data_i   (req_o.wr_data_en)
);

// File: sim/gpio_monitor.sv
`timescale 1ns/1ps

module gpio_monitor
    import ahb_pkg::*;
    import gpio_pkg::*;
#(
    parameter int NUM_PINS = 4
) (
    input  logic                hclk,
    input  logic                hresetn,
    input  logic                hsel_i,
    input  logic [1:0]          htrans_i,
    input  logic                hwrite_i,
    input  logic                hready_i,
    input  logic                hreadyout_i,
    input  logic                hresp_i,
    input  logic [31:0]         hrdata_i,
    input  wire  [NUM_PINS-1:0] pin_i,
    input  logic [31:0]         exp_rdata_i,
    input  logic                exp_err_i,
    input  logic [NUM_PINS-1:0] exp_pin_i,
    input  logic                pin_chk_i,
    output int                  rd_errors_o,
    output int                  resp_errors_o,
    output int                  pin_errors_o
);

    logic dphase_q;
    logic dread_q;
    logic wait_seen_q;
    logic exp_resp;
    logic exp_ready;

    // follow the bus into its data phase
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            dphase_q    <= 1'b0;
            dread_q     <= 1'b0;
            wait_seen_q <= 1'b0;
        end else if (hready_i) begin
            dphase_q    <= hsel_i && ((htrans_i == NONSEQ) || (htrans_i == SEQ));
            dread_q     <= !hwrite_i;
            wait_seen_q <= 1'b0;
        end else if (dphase_q && !hreadyout_i) begin
            wait_seen_q <= 1'b1;
        end
    end

    // the first error cycle is the only wait state
    assign exp_resp  = dphase_q && exp_err_i;
    assign exp_ready = !(exp_resp && !wait_seen_q);

    initial begin
        rd_errors_o   = 0;
        resp_errors_o = 0;
        pin_errors_o  = 0;
    end

    always @(posedge hclk) begin
        if (hresetn) begin
            if (hreadyout_i !== exp_ready) begin
                $display("error at %0t: hreadyout_o expected %b, got %b",
                         $time, exp_ready, hreadyout_i);
                resp_errors_o = resp_errors_o + 1;
            end
            if (hresp_i !== exp_resp) begin
                $display("error at %0t: hresp_o expected %b, got %b",
                         $time, exp_resp, hresp_i);
                resp_errors_o = resp_errors_o + 1;
            end
            if (dphase_q && dread_q && hreadyout_i && (hrdata_i !== exp_rdata_i)) begin
                $display("error at %0t: hrdata_o expected %h, got %h",
                         $time, exp_rdata_i, hrdata_i);
                rd_errors_o = rd_errors_o + 1;
            end
            if (pin_chk_i && (pin_i !== exp_pin_i)) begin
                $display("error at %0t: pin_io expected %b, got %b", $time, exp_pin_i, pin_i);
                pin_errors_o = pin_errors_o + 1;
            end
        end
    end

endmodule

// File: sim/tb_gpio_subsys.sv
`timescale 1ns/1ps

module tb_gpio_subsys
    import ahb_pkg::*;
    import gpio_pkg::*;
();

    localparam int NUM_PINS = 4;
    localparam int AWIDTH   = 32;
    localparam int N_RAND   = 40;
    localparam int N_XFER   = N_RAND + 40;
    localparam int PAD_WAIT = 150;
    localparam logic [31:0] CTRL_MASK = 32'((64'd1 << (2 * NUM_PINS)) - 1);

    typedef struct packed {
        logic                err;
        logic [31:0]         rdata;
        logic [NUM_PINS-1:0] pads;
    } ref_t;

    logic                hclk;
    logic                hresetn;
    logic                hsel;
    logic                hwrite;
    logic [AWIDTH-1:0]   haddr;
    logic [1:0]          htrans;
    logic [2:0]          hsize;
    logic [2:0]          hburst;
    logic [31:0]         hwdata;
    wire                 hreadyout;
    wire                 hresp;
    wire  [31:0]         hrdata;
    wire  [NUM_PINS-1:0] pin;

    logic [31:0]         ctrl_m;
    logic [NUM_PINS-1:0] data_m;
    logic [NUM_PINS-1:0] pad_val;
    logic [NUM_PINS-1:0] pad_en;
    logic [NUM_PINS-1:0] exp_pin;
    logic [31:0]         exp_rdata;
    logic                exp_err;
    logic                pin_chk;
    logic [31:0]         pend_wdata;
    logic [31:0]         pend_rdata;
    logic                pend_err;
    int                  seed;
    int                  op;
    int                  rd_err;
    int                  resp_err;
    int                  pin_err;
    int                  asrt_err;

    for (genvar i = 0; i < NUM_PINS; i++) begin : g_pad_drv
        assign pin[i] = pad_en[i] ? pad_val[i] : 1'bz;
    end

    gpio_subsys_top #(
        .AWIDTH   (AWIDTH),
        .NUM_PINS (NUM_PINS)
    ) i_dut (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .hsel_i      (hsel),
        .haddr_i     (haddr),
        .htrans_i    (htrans),
        .hwrite_i    (hwrite),
        .hsize_i     (hsize),
        .hburst_i    (hburst),
        .hready_i    (hreadyout),
        .hwdata_i    (hwdata),
        .hreadyout_o (hreadyout),
        .hresp_o     (hresp),
        .hrdata_o    (hrdata),
        .pin_io      (pin)
    );

    gpio_monitor #(
        .NUM_PINS (NUM_PINS)
    ) i_mon (
        .hclk          (hclk),
        .hresetn       (hresetn),
        .hsel_i        (hsel),
        .htrans_i      (htrans),
        .hwrite_i      (hwrite),
        .hready_i      (hreadyout),
        .hreadyout_i   (hreadyout),
        .hresp_i       (hresp),
        .hrdata_i      (hrdata),
        .pin_i         (pin),
        .exp_rdata_i   (exp_rdata),
        .exp_err_i     (exp_err),
        .exp_pin_i     (exp_pin),
        .pin_chk_i     (pin_chk),
        .rd_errors_o   (rd_err),
        .resp_errors_o (resp_err),
        .pin_errors_o  (pin_err)
    );

    initial begin
        hclk = 1'b0;
        forever #5 hclk = ~hclk;
    end

    function automatic logic [NUM_PINS-1:0] in_mask(input logic [31:0] ctrl);
        logic [NUM_PINS-1:0] m;
        for (int i = 0; i < NUM_PINS; i++) begin
            m[i] = (ctrl[2*i +: 2] == IN);
        end
        return m;
    endfunction

    // expected response and pad levels from the model registers
    function automatic ref_t gpio_ref(input logic [3:0] off, input logic [2:0] size);
        ref_t                r;
        logic [NUM_PINS-1:0] inm;
        inm     = in_mask(ctrl_m);
        r.err   = !(((off == gpio_data_off) || (off == gpio_ctrl_off)) && (size == hsize_word));
        r.rdata = '0;
        if (!r.err && (off == gpio_ctrl_off)) begin
            r.rdata = ctrl_m;
        end else if (!r.err) begin
            r.rdata[NUM_PINS-1:0] = (data_m & ~inm) | (pad_val & inm);
        end
        for (int i = 0; i < NUM_PINS; i++) begin
            case (ctrl_m[2*i +: 2])
                OUT:     r.pads[i] = data_m[i];
                IN:      r.pads[i] = pad_val[i];
                default: r.pads[i] = 1'bz;
            endcase
        end
        return r;
    endfunction

    // address phase now with the data of the previous transfer alongside
    task automatic xfer(input logic wr, input logic [3:0] off, input logic [2:0] size,
                        input logic [31:0] wdata);
        ref_t r;
        r = gpio_ref(off, size);
        hsel      <= 1'b1;
        htrans    <= NONSEQ;
        hwrite    <= wr;
        haddr     <= AWIDTH'(off);
        hsize     <= size;
        hwdata    <= pend_wdata;
        exp_rdata <= pend_rdata;
        exp_err   <= pend_err;
        do @(posedge hclk); while (!hreadyout);
        pend_wdata = wdata;
        pend_rdata = wr ? 32'h0 : r.rdata;
        pend_err   = r.err;
        if (wr && !r.err && (off == gpio_ctrl_off)) begin
            data_m = (data_m & ~in_mask(ctrl_m)) | (pad_val & in_mask(ctrl_m));
            ctrl_m = wdata & CTRL_MASK;
        end else if (wr && !r.err) begin
            data_m = wdata[NUM_PINS-1:0];
        end
    endtask

    task automatic idle();
        hsel      <= 1'b0;
        htrans    <= IDLE;
        hwdata    <= pend_wdata;
        exp_rdata <= pend_rdata;
        exp_err   <= pend_err;
        do @(posedge hclk); while (!hreadyout);
        pend_wdata = 32'h0;
        pend_rdata = 32'h0;
        pend_err   = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) idle();
    endtask

    task automatic check_pads();
        ref_t r;
        r = gpio_ref(gpio_data_off, hsize_word);
        exp_pin <= r.pads;
        pin_chk <= 1'b1;
        @(posedge hclk);
        pin_chk <= 1'b0;
    endtask

    // pads take the new modes three cycles after the write
    task automatic write_ctrl(input logic [31:0] value);
        xfer(1'b1, gpio_ctrl_off, hsize_word, value);
        idle();
        pad_en <= in_mask(ctrl_m);
        idle();
        check_pads();
        wait_cycles(4);
    endtask

    initial begin
        repeat (N_XFER * 20 + PAD_WAIT) @(posedge hclk);
        $display("timeout: the transfers did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seed       = 32'h3583_d975;
        hresetn    = 1'b0;
        hsel       = 1'b0;
        htrans     = IDLE;
        hwrite     = 1'b0;
        haddr      = '0;
        hsize      = hsize_word;
        hburst     = hburst_single;
        hwdata     = 32'h0;
        pad_val    = '0;
        pad_en     = '0;
        exp_pin    = '0;
        exp_rdata  = 32'h0;
        exp_err    = 1'b0;
        pin_chk    = 1'b0;
        pend_wdata = 32'h0;
        pend_rdata = 32'h0;
        pend_err   = 1'b0;
        ctrl_m     = 32'h0;
        data_m     = '0;
        repeat (2) @(posedge hclk);
        hresetn <= 1'b1;

        xfer(1'b0, gpio_data_off, hsize_word, 32'h0);
        xfer(1'b0, gpio_ctrl_off, hsize_word, 32'h0);
        idle();
        check_pads();

        write_ctrl($random(seed));
        xfer(1'b0, gpio_ctrl_off, hsize_word, 32'h0);
        xfer(1'b1, gpio_data_off, hsize_word, $random(seed));
        xfer(1'b0, gpio_data_off, hsize_word, 32'h0);
        idle();

        // pin 0 out, pin 1 hiz, pin 2 reserved, pin 3 in
        write_ctrl(32'hB1);
        xfer(1'b1, gpio_data_off, hsize_word, 32'hF);
        idle();
        wait_cycles(1);
        check_pads();

        pad_val <= '1;
        wait_cycles(4);
        xfer(1'b0, gpio_data_off, hsize_word, 32'h0);
        xfer(1'b1, gpio_data_off, hsize_word, 32'h0);
        xfer(1'b0, gpio_data_off, hsize_word, 32'h0);
        idle();
        check_pads();

        xfer(1'b1, 4'h8, hsize_word, $random(seed));
        xfer(1'b0, 4'hC, hsize_word, 32'h0);
        xfer(1'b0, gpio_data_off, 3'd0, 32'h0);
        xfer(1'b1, gpio_ctrl_off, 3'd0, 32'hFFFF_FFFF);
        xfer(1'b0, gpio_ctrl_off, hsize_word, 32'h0);
        xfer(1'b0, gpio_data_off, hsize_word, 32'h0);
        idle();

        repeat (N_RAND) begin
            op = $random(seed);
            if (op[3:0] == 4'h0) begin
                idle();
                write_ctrl($random(seed));
            end else if (op[3:0] == 4'h1) begin
                idle();
                pad_val <= NUM_PINS'($random(seed));
                wait_cycles(4);
            end else if (op[4]) begin
                xfer(1'b1, gpio_data_off, hsize_word, $random(seed));
            end else begin
                xfer(1'b0, op[5] ? gpio_ctrl_off : gpio_data_off, hsize_word, 32'h0);
            end
        end
        idle();
        wait_cycles(2);
        check_pads();
        wait_cycles(2);

        asrt_err = i_dut.i_ahb_if.i_bus_chk.fail_count;
        $display("errors: read data %0d, response %0d, pads %0d, assertions %0d",
                 rd_err, resp_err, pin_err, asrt_err);
        if ((rd_err + resp_err + pin_err + asrt_err) == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/ahb_pkg.sv
hdl/gpio_pkg.sv
hdl/gpio_ahb_if.sv
hdl/gpio_core.sv
hdl/gpio_subsys_top.sv
sim/gpio_bus_checker.sv
sim/gpio_monitor.sv
sim/tb_gpio_subsys.sv
